// ==== logic/tile_ctrl_pkg.sv ====
/*
 * Tile control package
 * Bus widths, control register map, error pattern and the Wishbone
 * request and response bundles shared by the tile control logic
 */
package tile_ctrl_pkg;

  ////////////////////
  // Sizes
  ////////////////////

  localparam int unsigned NumClusters = 4;
  localparam int unsigned NumMemTiles = 2;
  localparam int unsigned AddrWidth   = 12;
  localparam int unsigned DataWidth   = 32;
  localparam int unsigned NumCtrlRegs = 6;

  // Byte offset bits inside one bus word
  localparam int unsigned WordLsb = $clog2(DataWidth / 8);

  typedef logic [AddrWidth-1:0]   addr_t;
  typedef logic [DataWidth-1:0]   data_t;
  typedef logic [NumClusters-1:0] cluster_vec_t;
  typedef logic [NumMemTiles-1:0] mem_tile_vec_t;

  ////////////////////
  // Register map
  ////////////////////

  localparam addr_t RegWindowBase = 12'h100;
  // First byte address past the last register
  localparam addr_t RegWindowEnd  = addr_t'(RegWindowBase + NumCtrlRegs * (DataWidth / 8));
  // Read data for unmapped accesses
  localparam data_t ErrRespData   = 32'hBADCAB1E;

  typedef enum logic [2:0] {
    REG_CLUSTER_RST     = 3'd0,
    REG_CLUSTER_CLK_EN  = 3'd1,
    REG_MEM_TILE_RST    = 3'd2,
    REG_MEM_TILE_CLK_EN = 3'd3,
    REG_SPU_RST         = 3'd4,
    REG_SPU_CLK_EN      = 3'd5
  } ctrl_reg_e;

  // Implemented bits of each register, the rest reads as zero
  function automatic data_t ctrl_reg_mask(ctrl_reg_e idx);
    data_t mask;
    mask = '0;
    case (idx)
      REG_CLUSTER_RST, REG_CLUSTER_CLK_EN:   mask[NumClusters-1:0] = '1;
      REG_MEM_TILE_RST, REG_MEM_TILE_CLK_EN: mask[NumMemTiles-1:0] = '1;
      REG_SPU_RST, REG_SPU_CLK_EN:           mask[0] = 1'b1;
      default:                               mask = '0;
    endcase
    return mask;
  endfunction

  ////////////////////
  // Bundles
  ////////////////////

  typedef struct packed {
    logic  cyc;
    logic  stb;
    logic  we;
    addr_t adr;
    data_t dat;
  } wb_req_t;

  typedef struct packed {
    logic  ack;
    logic  err;
    data_t dat;
  } wb_rsp_t;

  // Reset lines are active low, 0 holds the unit in reset
  typedef struct packed {
    cluster_vec_t  cluster_rst_n;
    cluster_vec_t  cluster_clk_en;
    mem_tile_vec_t mem_tile_rst_n;
    mem_tile_vec_t mem_tile_clk_en;
    logic          spu_rst_n;
    logic          spu_clk_en;
  } tile_ctrl_t;

endpackage

// ==== logic/tile_bus_decoder.sv ====
/*
 * Tile bus decoder
 * Splits Wishbone traffic between the control register window and an
 * error slave that answers every unmapped address
 */
`timescale 1ns/10ps

module tile_bus_decoder (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  // Upstream master
  input  tile_ctrl_pkg::wb_req_t mst_req_i,
  output tile_ctrl_pkg::wb_rsp_t mst_rsp_o,
  // Register bank
  output tile_ctrl_pkg::wb_req_t reg_req_o,
  input  tile_ctrl_pkg::wb_rsp_t reg_rsp_i
);

  import tile_ctrl_pkg::*;

  logic    in_window;
  logic    req_valid;
  logic    err_q;
  wb_rsp_t err_rsp;

  ////////////////////
  // Address decode
  ////////////////////

  // Window check on byte addresses, low offset bits are don't care
  assign in_window = (mst_req_i.adr >= RegWindowBase) &&
                     (mst_req_i.adr <  RegWindowEnd);

  assign req_valid = mst_req_i.cyc && mst_req_i.stb;

  // Only in-window strobes reach the register bank
  always_comb begin
    reg_req_o     = mst_req_i;
    reg_req_o.stb = mst_req_i.stb && in_window;
  end

  ////////////////////
  // Error slave
  ////////////////////

  // Same one-cycle latency as the register bank.
  // A held request must not produce a second err pulse
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      err_q <= 1'b0;
    end else begin
      err_q <= req_valid && !in_window && !err_q;
    end
  end

  always_comb begin
    err_rsp     = '0;
    err_rsp.err = err_q;
    err_rsp.dat = ErrRespData;
  end

  ////////////////////
  // Response select
  ////////////////////

  // Only one access is in flight, so the two sources never answer together
  always_comb begin
    if (err_q) begin
      mst_rsp_o = err_rsp;
    end else begin
      mst_rsp_o = reg_rsp_i;
    end
  end

endmodule

// ==== logic/tile_ctrl_regs.sv ====
/*
 * Tile control registers
 * Six Wishbone registers that drive cluster, memory tile and accelerator
 * resets and clock enables
 */
`timescale 1ns/10ps

module tile_ctrl_regs (
  input  logic                      clk_i,
  input  logic                      rst_n_i,
  // Wishbone slave port
  input  tile_ctrl_pkg::wb_req_t    wb_req_i,
  output tile_ctrl_pkg::wb_rsp_t    wb_rsp_o,
  // Reset and clock-enable lines
  output tile_ctrl_pkg::tile_ctrl_t tile_ctrl_o
);

  import tile_ctrl_pkg::*;

  data_t     ctrl_q [NumCtrlRegs];
  ctrl_reg_e req_idx;
  logic      idx_valid;
  logic      req_fire;
  data_t     wr_data;
  data_t     rd_data;
  logic      ack_q;
  data_t     rdata_q;

  ////////////////////
  // Access decode
  ////////////////////

  // Low word address bits select the register, the window is checked upstream
  assign req_idx   = ctrl_reg_e'(wb_req_i.adr[WordLsb +: $bits(ctrl_reg_e)]);
  assign idx_valid = (req_idx < NumCtrlRegs);

  // New access only while no ack is pending
  assign req_fire = wb_req_i.cyc && wb_req_i.stb && !ack_q;

  assign wr_data = wb_req_i.dat & ctrl_reg_mask(req_idx);

  always_comb begin
    rd_data = '0;
    if (idx_valid) begin
      rd_data = ctrl_q[req_idx];
    end
  end

  ////////////////////
  // Register file
  ////////////////////

  // Write lands on the same edge that raises ack
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      for (int i = 0; i < NumCtrlRegs; i++) begin
        ctrl_q[i] <= '0;
      end
    end else if (req_fire && wb_req_i.we && idx_valid) begin
      ctrl_q[req_idx] <= wr_data;
    end
  end

  ////////////////////
  // Bus response
  ////////////////////

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= req_fire;
    end
  end

  // Read data captured with the ack
  always_ff @(posedge clk_i) begin
    if (req_fire && !wb_req_i.we) begin
      rdata_q <= rd_data;
    end
  end

  always_comb begin
    wb_rsp_o     = '0;
    wb_rsp_o.ack = ack_q;
    wb_rsp_o.dat = rdata_q;
  end

  ////////////////////
  // Control outputs
  ////////////////////

  // Straight from the register contents, zero while reset clears them
  always_comb begin
    tile_ctrl_o.cluster_rst_n   = ctrl_q[REG_CLUSTER_RST][NumClusters-1:0];
    tile_ctrl_o.cluster_clk_en  = ctrl_q[REG_CLUSTER_CLK_EN][NumClusters-1:0];
    tile_ctrl_o.mem_tile_rst_n  = ctrl_q[REG_MEM_TILE_RST][NumMemTiles-1:0];
    tile_ctrl_o.mem_tile_clk_en = ctrl_q[REG_MEM_TILE_CLK_EN][NumMemTiles-1:0];
    tile_ctrl_o.spu_rst_n       = ctrl_q[REG_SPU_RST][0];
    tile_ctrl_o.spu_clk_en      = ctrl_q[REG_SPU_CLK_EN][0];
  end

endmodule

// ==== logic/tile_ctrl_top.sv ====
/*
 * Tile control top level
 * Bus decoder in front of the reset and clock-gating register bank
 */
`timescale 1ns/10ps

module tile_ctrl_top (
  input  logic                      clk_i,
  input  logic                      rst_n_i,
  // Wishbone slave port from the SoC
  input  tile_ctrl_pkg::wb_req_t    wb_req_i,
  output tile_ctrl_pkg::wb_rsp_t    wb_rsp_o,
  // Tile resets and clock enables
  output tile_ctrl_pkg::tile_ctrl_t tile_ctrl_o
);

  import tile_ctrl_pkg::*;

  // Decoder to register bank
  wb_req_t reg_req;
  wb_rsp_t reg_rsp;

  ////////////////////
  // Decoder
  ////////////////////

  tile_bus_decoder u_bus_decoder (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .mst_req_i (wb_req_i),
    .mst_rsp_o (wb_rsp_o),
    .reg_req_o (reg_req),
    .reg_rsp_i (reg_rsp)
  );

  ////////////////////
  // Register bank
  ////////////////////

  tile_ctrl_regs u_ctrl_regs (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .wb_req_i    (reg_req),
    .wb_rsp_o    (reg_rsp),
    .tile_ctrl_o (tile_ctrl_o)
  );

endmodule

// ==== verif/tile_ctrl_assert.sv ====
/*
 * Tile control handshake assertions
 * Wishbone response timing at the top level ports
 */
`timescale 1ns/10ps

module tile_ctrl_assert (
  input logic                   clk_i,
  input logic                   rst_n_i,
  input tile_ctrl_pkg::wb_req_t wb_req_i,
  input tile_ctrl_pkg::wb_rsp_t wb_rsp_o
);

  logic        req_valid;
  logic        rsp_valid;
  // Count of failed assertions
  int unsigned fail_count = 0;

  assign req_valid = wb_req_i.cyc && wb_req_i.stb;
  assign rsp_valid = wb_rsp_o.ack || wb_rsp_o.err;

  // Response exactly one cycle after the request is first sampled
  a_rsp_latency: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $rose(req_valid) |=> rsp_valid)
    else begin
      fail_count++;
      $error("ack or err missing one cycle after a new request");
    end

  a_rsp_single: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    rsp_valid |=> !rsp_valid)
    else begin
      fail_count++;
      $error("ack or err held for more than one cycle");
    end

  a_ack_err_excl: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !(wb_rsp_o.ack && wb_rsp_o.err))
    else begin
      fail_count++;
      $error("ack and err high together");
    end

  a_reset_quiet: assert property (@(posedge clk_i)
    !rst_n_i |=> !rsp_valid)
    else begin
      fail_count++;
      $error("ack or err high in the cycle after reset");
    end

endmodule

bind tile_ctrl_top tile_ctrl_assert u_assert (.*);

// ==== verif/tile_ctrl_checker.sv ====
/*
 * Tile control checker
 * Reference model of the six control registers, compares every bus
 * response and the reset and clock-enable outputs with the model
 */
`timescale 1ns/10ps

module tile_ctrl_checker (
  input  logic                      clk_i,
  input  logic                      rst_n_i,
  input  tile_ctrl_pkg::wb_req_t    wb_req_i,
  input  tile_ctrl_pkg::wb_rsp_t    wb_rsp_i,
  input  tile_ctrl_pkg::tile_ctrl_t tile_ctrl_i,
  // 0 while the reset state is read, 1 during random traffic
  input  logic                      test_id_i,
  output int unsigned               check_count_o,
  output int unsigned               error_count_o
);

  import tile_ctrl_pkg::*;

  localparam addr_t WindowEnd = RegWindowBase + addr_t'(NumCtrlRegs * 4);

  data_t       model_q [NumCtrlRegs];
  logic        pending_q;
  wb_req_t     pend_req_q;
  int unsigned check_count = 0;
  int unsigned error_count = 0;

  assign check_count_o = check_count;
  assign error_count_o = error_count;

  function automatic string test_name();
    return test_id_i ? "random_access" : "reset_state";
  endfunction

  function automatic logic addr_in_window(addr_t adr);
    return (adr >= RegWindowBase) && (adr < WindowEnd);
  endfunction

  function automatic int reg_index(addr_t adr);
    return int'((adr - RegWindowBase) >> 2);
  endfunction

  // Clusters first, then memory tiles, then the single accelerator bits
  function automatic data_t width_mask(int idx);
    int width;
    if (idx < 2) begin
      width = NumClusters;
    end else if (idx < 4) begin
      width = NumMemTiles;
    end else begin
      width = 1;
    end
    return data_t'((64'd1 << width) - 64'd1);
  endfunction

  function automatic tile_ctrl_t expected_ctrl();
    tile_ctrl_t ctrl;
    ctrl.cluster_rst_n   = cluster_vec_t'(model_q[0]);
    ctrl.cluster_clk_en  = cluster_vec_t'(model_q[1]);
    ctrl.mem_tile_rst_n  = mem_tile_vec_t'(model_q[2]);
    ctrl.mem_tile_clk_en = mem_tile_vec_t'(model_q[3]);
    ctrl.spu_rst_n       = model_q[4][0];
    ctrl.spu_clk_en      = model_q[5][0];
    return ctrl;
  endfunction

  task automatic check_value(string what, data_t expected, data_t actual);
    check_count = check_count + 1;
    if (actual !== expected) begin
      error_count = error_count + 1;
      $display("[ERROR] %s %s: expected 0x%08h, actual 0x%08h",
               test_name(), what, expected, actual);
    end
  endtask

  task automatic note_failure(string what);
    error_count = error_count + 1;
    $display("%s: %s", test_name(), what);
  endtask

  task automatic check_response(wb_req_t req);
    int idx;
    data_t kind;
    kind = data_t'({wb_rsp_i.ack, wb_rsp_i.err});
    if (addr_in_window(req.adr)) begin
      idx = reg_index(req.adr);
      check_value($sformatf("ack/err at 0x%03h", req.adr), data_t'(2'b10), kind);
      if (req.we) begin
        model_q[idx] = req.dat & width_mask(idx);
      end else begin
        check_value($sformatf("read data at 0x%03h", req.adr), model_q[idx], wb_rsp_i.dat);
      end
    end else begin
      // Unmapped access leaves the model untouched
      check_value($sformatf("ack/err at 0x%03h", req.adr), data_t'(2'b01), kind);
      check_value($sformatf("error data at 0x%03h", req.adr), ErrRespData, wb_rsp_i.dat);
    end
  endtask

  ////////////////////
  // Sampling
  ////////////////////

  // Sampled on rising edges, stimulus changes on falling edges
  always @(posedge clk_i) begin
    logic rsp_seen;
    if (!rst_n_i) begin
      for (int i = 0; i < NumCtrlRegs; i++) begin
        model_q[i] = '0;
      end
      pending_q = 1'b0;
    end else begin
      rsp_seen = wb_rsp_i.ack || wb_rsp_i.err;
      if (pending_q) begin
        if (rsp_seen) begin
          check_response(pend_req_q);
        end else begin
          note_failure($sformatf("no bus response one cycle after request to 0x%03h",
                                 pend_req_q.adr));
        end
        pending_q = 1'b0;
      end else if (rsp_seen) begin
        note_failure("bus response without a request");
      end
      // Outputs track the model, including a write acked this cycle
      check_value("tile_ctrl_o", data_t'(expected_ctrl()), data_t'(tile_ctrl_i));
      if (wb_req_i.cyc && wb_req_i.stb && !rsp_seen) begin
        pending_q  = 1'b1;
        pend_req_q = wb_req_i;
      end
    end
  end

endmodule

// ==== verif/tile_ctrl_tb.sv ====
/*
 * Tile control testbench
 * Reads the reset state, then runs seeded random Wishbone traffic
 * against the register window and unmapped addresses
 */
`timescale 1ns/10ps

module tile_ctrl_tb;

  import tile_ctrl_pkg::*;

  localparam int unsigned NumTxns    = 200;
  localparam int unsigned CycleLimit = NumTxns * 3 + 100;
  localparam addr_t       WindowEnd  = RegWindowBase + addr_t'(NumCtrlRegs * 4);

  logic        clk_i;
  logic        rst_n_i;
  wb_req_t     wb_req;
  wb_rsp_t     wb_rsp;
  tile_ctrl_t  tile_ctrl;
  logic        test_id;
  int unsigned check_count;
  int unsigned error_count;
  int unsigned errors_before;
  int unsigned txn_count;
  int unsigned cycle_count;
  int unsigned total_errors;
  integer      seed;

  tile_ctrl_top u_dut (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .wb_req_i    (wb_req),
    .wb_rsp_o    (wb_rsp),
    .tile_ctrl_o (tile_ctrl)
  );

  tile_ctrl_checker u_checker (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .wb_req_i      (wb_req),
    .wb_rsp_i      (wb_rsp),
    .tile_ctrl_i   (tile_ctrl),
    .test_id_i     (test_id),
    .check_count_o (check_count),
    .error_count_o (error_count)
  );

  initial clk_i = 1'b0;
  always #20 clk_i = ~clk_i;

  // One Wishbone classic access, starting and ending on a falling edge
  task automatic bus_access(input logic we, input addr_t adr, input data_t dat);
    wb_req.cyc = 1'b1;
    wb_req.stb = 1'b1;
    wb_req.we  = we;
    wb_req.adr = adr;
    wb_req.dat = dat;
    @(negedge clk_i);
    while (!(wb_rsp.ack || wb_rsp.err)) begin
      @(negedge clk_i);
    end
    wb_req = '0;
    // Idle cycle between requests
    @(negedge clk_i);
    txn_count = txn_count + 1;
  endtask

  task automatic report_test(string name);
    $display("Test %s done: %0d transactions, %0d errors",
             name, txn_count, error_count - errors_before);
  endtask

  ////////////////////
  // Stimulus
  ////////////////////

  initial begin
    int unsigned pick;
    int unsigned idx;
    logic [31:0] rnd;
    addr_t       adr;
    rst_n_i   = 1'b0;
    wb_req    = '0;
    test_id   = 1'b0;
    txn_count = 0;
    seed      = 32'h6268;
    repeat (2) @(negedge clk_i);
    rst_n_i = 1'b1;

    errors_before = error_count;
    for (int i = 0; i < NumCtrlRegs; i++) begin
      bus_access(1'b0, RegWindowBase + addr_t'(i * 4), '0);
    end
    report_test("reset_state");

    test_id       = 1'b1;
    errors_before = error_count;
    txn_count     = 0;
    while (txn_count < NumTxns) begin
      pick = {$random(seed)} % 10;
      if (pick < 8) begin
        idx = {$random(seed)} % NumCtrlRegs;
        adr = RegWindowBase + addr_t'(idx * 4);
      end else begin
        adr = addr_t'($random(seed));
        if (adr >= RegWindowBase && adr < WindowEnd) begin
          adr = adr ^ 12'h400;
        end
      end
      rnd = $random(seed);
      bus_access(rnd[0], adr, data_t'($random(seed)));
      // Read back some in-window writes right away
      if (rnd[0] && rnd[1] && pick < 8 && txn_count < NumTxns) begin
        bus_access(1'b0, adr, data_t'($random(seed)));
      end
    end
    report_test("random_access");

    total_errors = error_count + u_dut.u_assert.fail_count;
    $display("Summary: 2 tests, %0d checks, %0d checker errors, %0d assertion failures",
             check_count, error_count, u_dut.u_assert.fail_count);
    if (total_errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

  ////////////////////
  // Timeout
  ////////////////////

  initial begin
    cycle_count = 0;
    while (cycle_count < CycleLimit) begin
      @(posedge clk_i);
      cycle_count = cycle_count + 1;
    end
    $display("Timeout: the tests did not complete within %0d clock cycles", CycleLimit);
    $display("Finished with errors");
    $finish;
  end

endmodule

// ==== sim.f ====
logic/tile_ctrl_pkg.sv
logic/tile_bus_decoder.sv
logic/tile_ctrl_regs.sv
logic/tile_ctrl_top.sv
verif/tile_ctrl_assert.sv
verif/tile_ctrl_checker.sv
verif/tile_ctrl_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the tile control testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
SIM_BIN=tile_ctrl_sim
LOG_FILE=sim.log

verilator --binary --timing --assert \
  -f sim.f \
  --top-module tile_ctrl_tb \
  -Mdir "$BUILD_DIR" \
  -o "$SIM_BIN"
status=$?
if [ "$status" -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

"./$BUILD_DIR/$SIM_BIN" +verilator+error+limit+100 > "$LOG_FILE" 2>&1
status=$?
cat "$LOG_FILE"
if [ "$status" -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -qx "Finished with no errors" "$LOG_FILE"; then
  echo "Simulation passed"
  exit 0
else
  echo "Simulation failed, see $LOG_FILE"
  exit 1
fi
